// ==== hw/vid_timing_pkg.sv ====
/*
 * Video timing generator types and constants
 */
`default_nettype none

package vid_timing_pkg;

  // --------------------------------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------------------------------
  localparam int h_width = 15;
  localparam int v_width = 11;
  localparam int eav_words = 8;
  localparam int sav_words = 4;

  // Timing reference and blanking symbols
  localparam logic [9:0] trs_preamble = 10'h3ff;
  localparam logic [9:0] black_luma = 10'h040;
  localparam logic [9:0] black_chroma = 10'h200;

  // SMPTE 352 sampling structures that carry RGB
  localparam logic [3:0] structure_444_rgb = 4'h2;
  localparam logic [3:0] structure_4444_rgba = 4'h6;
  localparam logic [3:0] structure_4444_rgbd = 4'ha;

  localparam logic interlace_code = 1'b1;

  // --------------------------------------------------------------------------
  // Video standard word
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [3:0] rsvd_31_28;
    logic [3:0] interface_code;
    logic       interlace;
    logic [2:0] rsvd_22_20;
    logic [3:0] picture_rate;
    logic [3:0] rsvd_15_12;
    logic [3:0] structure;
    logic [7:0] rsvd_7_0;
  } vid_std_fields_t;

  typedef union packed {
    logic [31:0]     raw;
    vid_std_fields_t fields;
  } vid_std_u;

  // Raster geometry, all line and sample numbers count from 1
  typedef struct packed {
    logic [h_width-1:0] h_limit;
    logic [h_width-1:0] h_sav;
    logic [v_width-1:0] v_limit;
    logic [v_width-1:0] v1_start;
    logic [v_width-1:0] v1_end;
    logic [v_width-1:0] v2_start;
    logic [v_width-1:0] v2_end;
    logic [v_width-1:0] f1_start;
    logic [v_width-1:0] f2_start;
  } raster_cfg_t;

  // --------------------------------------------------------------------------
  // Pipeline items
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    phase_none,
    phase_eav,
    phase_sav
  } trs_phase_e;

  typedef struct packed {
    logic [h_width-1:0] h_pos;
    logic [v_width-1:0] v_pos;
    trs_phase_e         phase;
    logic [2:0]         trs_index;
  } raster_pos_t;

  typedef struct packed {
    raster_pos_t        pos;
    logic               f;
    logic               v;
    logic               h;
    logic [v_width-1:0] pic_line;
  } line_state_t;

  typedef struct packed {
    logic [19:0] data;
    logic        trs;
    logic [2:0]  fvh;
  } vid_word_t;

endpackage

`default_nettype wire

// ==== hw/raster_counter.sv ====
/*
 * Raster position counter
 */
`timescale 1ns/1ns
`default_nettype none

module raster_counter import vid_timing_pkg::*; (
  input  logic        vid_clk,
  input  logic        vid_reset,
  input  logic        advance,
  input  raster_cfg_t cfg,
  output raster_pos_t pos
);

  raster_pos_t pos_next;
  logic        h_end;
  logic        v_end;

  assign h_end = (pos.h_pos == cfg.h_limit);
  assign v_end = (pos.v_pos == cfg.v_limit);

  // --------------------------------------------------------------------------
  // Next sample position
  // --------------------------------------------------------------------------
  always_comb begin
    pos_next = pos;

    if (h_end) begin
      pos_next.h_pos = h_width'(1);
      pos_next.v_pos = v_end ? v_width'(1) : pos.v_pos + v_width'(1);
    end else begin
      pos_next.h_pos = pos.h_pos + h_width'(1);
    end

    // EAV opens every line, SAV follows sample h_sav
    if (h_end) begin
      pos_next.phase = phase_eav;
      pos_next.trs_index = '0;
    end else if (pos.phase == phase_eav && pos.trs_index != 3'(eav_words - 1)) begin
      pos_next.trs_index = pos.trs_index + 3'd1;
    end else if (pos.h_pos == cfg.h_sav) begin
      pos_next.phase = phase_sav;
      pos_next.trs_index = '0;
    end else if (pos.phase == phase_sav && pos.trs_index != 3'(sav_words - 1)) begin
      pos_next.trs_index = pos.trs_index + 3'd1;
    end else begin
      pos_next.phase = phase_none;
      pos_next.trs_index = '0;
    end
  end

  // --------------------------------------------------------------------------
  // Position register
  // --------------------------------------------------------------------------
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      // Parked on the last sample of the frame
      // first advance yields line 1, sample 1
      pos.h_pos <= cfg.h_limit;
      pos.v_pos <= cfg.v_limit;
      pos.phase <= phase_none;
      pos.trs_index <= '0;
    end else if (advance) begin
      pos <= pos_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/line_flags.sv ====
/*
 * Field, blanking and line number flags
 */
`timescale 1ns/1ns
`default_nettype none

module line_flags import vid_timing_pkg::*; (
  input  logic        vid_clk,
  input  logic        vid_reset,
  input  logic        advance,
  input  raster_cfg_t cfg,
  input  vid_std_u    std_word,
  input  raster_pos_t pos,
  output line_state_t state
);

  logic               eav_start;
  logic               sav_last;
  logic               v_set;
  logic               v_clear;
  logic               f_set;
  logic               f_clear;
  logic               v_next;
  logic               f_next;
  logic [v_width-1:0] pic_step;

  assign eav_start = (pos.phase == phase_eav) && (pos.trs_index == '0);

  // Held item is the previous sample, so its last SAV word ends H
  assign sav_last = (state.pos.phase == phase_sav) &&
                    (state.pos.trs_index == 3'(sav_words - 1));

  // --------------------------------------------------------------------------
  // Line boundary compares
  // --------------------------------------------------------------------------
  assign v_set = (pos.v_pos == cfg.v1_end) || (pos.v_pos == cfg.v2_end);
  assign v_clear = (pos.v_pos == cfg.v1_start) || (pos.v_pos == cfg.v2_start);
  assign f_set = (pos.v_pos == cfg.f2_start);
  assign f_clear = (pos.v_pos == cfg.f1_start);

  always_comb begin
    v_next = state.v;
    if (v_set) begin
      v_next = 1'b1;
    end else if (v_clear) begin
      v_next = 1'b0;
    end

    f_next = state.f;
    if (f_set) begin
      f_next = 1'b1;
    end else if (f_clear) begin
      f_next = 1'b0;
    end
  end

  // Interlaced pictures number their lines across both fields
  assign pic_step = (std_word.fields.interlace == interlace_code) ?
                    v_width'(2) : v_width'(1);

  // --------------------------------------------------------------------------
  // Flag and position register
  // --------------------------------------------------------------------------
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      state.pos <= '0;
      state.f <= 1'b1;
      state.v <= 1'b1;
      state.h <= 1'b1;
      state.pic_line <= '0;
    end else if (advance) begin
      state.pos <= pos;
      if (eav_start) begin
        state.f <= f_next;
        state.v <= v_next;
        state.h <= 1'b1;
        // Old V still held here marks the first active line
        if (v_next) begin
          state.pic_line <= '0;
        end else if (state.v) begin
          state.pic_line <= f_next ? v_width'(2) : v_width'(1);
        end else begin
          state.pic_line <= state.pic_line + pic_step;
        end
      end else if (sav_last) begin
        state.h <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/trs_formatter.sv ====
/*
 * Output word formatter and handshake
 */
`timescale 1ns/1ns
`default_nettype none

module trs_formatter import vid_timing_pkg::*; (
  input  logic        vid_clk,
  input  logic        vid_reset,
  input  vid_std_u    std_word,
  input  line_state_t state,
  output logic        advance,
  output vid_word_t   out_word,
  output logic        out_valid,
  input  logic        out_ready
);

  logic [9:0]  xyz;
  logic [9:0]  trs_sym;
  logic        rgb_black;
  logic [19:0] blank_data;
  vid_word_t   word_next;
  logic [1:0]  fill_count;

  // Line number words, low bits then high bits
  function automatic logic [9:0] ln_low(input logic [v_width-1:0] line);
    return {~line[6], line[6:0], 2'b00};
  endfunction

  function automatic logic [9:0] ln_high(input logic [v_width-1:0] line);
    return {4'b1000, line[10:7], 2'b00};
  endfunction

  // Whole pipeline moves when the output slot is free or being taken
  assign advance = ~out_valid | out_ready;

  // --------------------------------------------------------------------------
  // Timing reference symbols
  // --------------------------------------------------------------------------
  assign xyz = {1'b1, state.f, state.v, state.h,
                state.v ^ state.h,
                state.f ^ state.h,
                state.f ^ state.v,
                state.f ^ state.v ^ state.h,
                2'b00};

  always_comb begin
    case (state.pos.trs_index)
      3'd0: trs_sym = trs_preamble;
      3'd1, 3'd2: trs_sym = 10'h000;
      3'd3: trs_sym = xyz;
      3'd4: trs_sym = ln_low(state.pos.v_pos);
      3'd5: trs_sym = ln_high(state.pos.v_pos);
      3'd6: trs_sym = ln_low(state.pic_line);
      default: trs_sym = ln_high(state.pic_line);
    endcase
  end

  // --------------------------------------------------------------------------
  // Blanking level
  // --------------------------------------------------------------------------
  always_comb begin
    case (std_word.fields.structure)
      structure_444_rgb, structure_4444_rgba, structure_4444_rgbd: rgb_black = 1'b1;
      default: rgb_black = 1'b0;
    endcase
  end

  assign blank_data = {black_luma, rgb_black ? black_luma : black_chroma};

  always_comb begin
    word_next.fvh = {state.f, state.v, state.h};
    if (state.pos.phase == phase_none) begin
      word_next.data = blank_data;
      word_next.trs = 1'b0;
    end else begin
      // Same symbol on luma and chroma
      word_next.data = {trs_sym, trs_sym};
      word_next.trs = (state.pos.trs_index == '0);
    end
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  // Two advances fill the earlier stages after reset
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      fill_count <= '0;
      out_valid <= 1'b0;
    end else if (advance) begin
      if (fill_count != 2'd2) begin
        fill_count <= fill_count + 2'd1;
      end
      out_valid <= (fill_count == 2'd2);
    end
  end

  always_ff @(posedge vid_clk) begin
    if (advance) begin
      out_word <= word_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vid_timing_gen.sv ====
/*
 * Test raster generator top level
 */
`timescale 1ns/1ns
`default_nettype none

module vid_timing_gen import vid_timing_pkg::*; (
  input  logic        vid_clk,
  input  logic        vid_reset,
  input  raster_cfg_t cfg,
  input  vid_std_u    std_word,
  output vid_word_t   out_word,
  output logic        out_valid,
  input  logic        out_ready
);

  raster_pos_t pos;
  line_state_t state;
  logic        advance;

  // Sample and line counters
  raster_counter raster_counter_i (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .advance   (advance),
    .cfg       (cfg),
    .pos       (pos)
  );

  // F, V, H and picture line
  line_flags line_flags_i (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .advance   (advance),
    .cfg       (cfg),
    .std_word  (std_word),
    .pos       (pos),
    .state     (state)
  );

  // Word build and output handshake
  trs_formatter trs_formatter_i (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .std_word  (std_word),
    .state     (state),
    .advance   (advance),
    .out_word  (out_word),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== include/vid_timing_model.svh ====
/*
 * Video timing reference model
 */
`ifndef VID_TIMING_MODEL_SVH
`define VID_TIMING_MODEL_SVH

// Position and flags of the next expected word
typedef struct packed {
  logic [h_width-1:0] h_pos;
  logic [v_width-1:0] v_pos;
  logic               f;
  logic               v;
  logic [v_width-1:0] pic_line;
} model_state_t;

function automatic logic is_rgb_std(input vid_std_u std_w);
  return (std_w.fields.structure == structure_444_rgb) ||
         (std_w.fields.structure == structure_4444_rgba) ||
         (std_w.fields.structure == structure_4444_rgbd);
endfunction

// Symbol at a given index inside EAV or SAV
function automatic logic [9:0] trs_symbol(input int idx, input logic f, input logic v,
                                          input logic h,
                                          input logic [v_width-1:0] line,
                                          input logic [v_width-1:0] pic);
  logic [v_width-1:0] num;
  num = (idx < 6) ? line : pic;
  case (idx)
    0: return trs_preamble;
    1, 2: return 10'h000;
    3: return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h, 2'b00};
    4, 6: return {~num[6], num[6:0], 2'b00};
    default: return {4'b1000, num[10:7], 2'b00};
  endcase
endfunction

// Advance one accepted word and update the flags on the first sample of a line
function automatic model_state_t next_position(input raster_cfg_t cfg, input vid_std_u std_w,
                                               input model_state_t st);
  model_state_t nx;
  nx = st;
  if (st.h_pos == cfg.h_limit) begin
    nx.h_pos = h_width'(1);
    nx.v_pos = (st.v_pos == cfg.v_limit) ? v_width'(1) : st.v_pos + v_width'(1);
    if (nx.v_pos == cfg.v1_end || nx.v_pos == cfg.v2_end) begin
      nx.v = 1'b1;
    end else if (nx.v_pos == cfg.v1_start || nx.v_pos == cfg.v2_start) begin
      nx.v = 1'b0;
    end
    if (nx.v_pos == cfg.f2_start) begin
      nx.f = 1'b1;
    end else if (nx.v_pos == cfg.f1_start) begin
      nx.f = 1'b0;
    end
    if (nx.v) begin
      nx.pic_line = '0;
    end else if (st.v) begin
      nx.pic_line = nx.f ? v_width'(2) : v_width'(1);
    end else if (std_w.fields.interlace == interlace_code) begin
      nx.pic_line = st.pic_line + v_width'(2);
    end else begin
      nx.pic_line = st.pic_line + v_width'(1);
    end
  end else begin
    nx.h_pos = st.h_pos + h_width'(1);
  end
  return nx;
endfunction

// State for the first word after reset
function automatic model_state_t first_position(input raster_cfg_t cfg, input vid_std_u std_w);
  model_state_t st;
  st.h_pos = cfg.h_limit;
  st.v_pos = cfg.v_limit;
  st.f = 1'b1;
  st.v = 1'b1;
  st.pic_line = '0;
  return next_position(cfg, std_w, st);
endfunction

// Expected word at the current model position
function automatic vid_word_t expected_word(input raster_cfg_t cfg, input vid_std_u std_w,
                                            input model_state_t st);
  vid_word_t  w;
  logic       h;
  logic [9:0] sym;
  int         sav_idx;
  h = (st.h_pos <= cfg.h_sav + h_width'(sav_words));
  sav_idx = int'(st.h_pos) - int'(cfg.h_sav) - 1;
  w.fvh = {st.f, st.v, h};
  w.trs = 1'b0;
  if (st.h_pos <= h_width'(eav_words)) begin
    sym = trs_symbol(int'(st.h_pos) - 1, st.f, st.v, h, st.v_pos, st.pic_line);
    w.data = {sym, sym};
    w.trs = (st.h_pos == h_width'(1));
  end else if (sav_idx >= 0 && sav_idx < sav_words) begin
    sym = trs_symbol(sav_idx, st.f, st.v, h, st.v_pos, st.pic_line);
    w.data = {sym, sym};
    w.trs = (sav_idx == 0);
  end else if (is_rgb_std(std_w)) begin
    w.data = {black_luma, black_luma};
  end else begin
    w.data = {black_luma, black_chroma};
  end
  return w;
endfunction

`endif

// ==== sim/vid_timing_tb.sv ====
/*
 * Video timing generator testbench
 */
`timescale 1ns/1ns
`default_nettype none

module vid_timing_tb import vid_timing_pkg::*; ();

  `include "vid_timing_model.svh"

  localparam int row_fields = 14;
  localparam int max_rows = 8;
  localparam int reset_cycles = 8;

  logic        vid_clk;
  logic        vid_reset;
  raster_cfg_t cfg;
  vid_std_u    std_word;
  vid_word_t   out_word;
  logic        out_valid;
  logic        out_ready;

  // One row of the input file per test configuration
  logic [31:0] stim_mem [0:max_rows*row_fields-1];
  int          row_count;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          cur_line;
  int          cur_sample;

  vid_timing_gen dut_i (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .cfg       (cfg),
    .std_word  (std_word),
    .out_word  (out_word),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    vid_clk = 1'b0;
    forever #5 vid_clk = ~vid_clk;
  end

  // --------------------------------------------------------------------------
  // Error reporting
  // --------------------------------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    $display("mismatch at %0t: %s got %h expected %h (line %0d sample %0d)",
             $time, name, got, expected, cur_line, cur_sample);
    stop_on_error("checked value differs from its expected value");
  endtask

  always @(posedge vid_clk) begin
    cycle_count <= cycle_count + 1;
    assert (cycle_limit == 0 || cycle_count < cycle_limit)
      else stop_on_error($sformatf("timeout, run not done after %0d cycles", cycle_count));
  end

  function automatic logic pick_ready(input int pct);
    return int'($urandom % 100) < pct;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus file
  // --------------------------------------------------------------------------
  task automatic load_stimulus();
    int total_words;
    int min_pct;
    int base;
    for (int i = 0; i < max_rows * row_fields; i++) begin
      stim_mem[i] = '1;
    end
    $readmemh("sim/timing_input.txt", stim_mem);
    row_count = 0;
    while (row_count < max_rows && stim_mem[row_count * row_fields] != '1) begin
      row_count++;
    end
    assert (row_count > 0) else stop_on_error("no test rows read from sim/timing_input.txt");
    total_words = 0;
    min_pct = 100;
    for (int r = 0; r < row_count; r++) begin
      base = r * row_fields;
      total_words += int'(stim_mem[base][h_width-1:0]) *
                     int'(stim_mem[base + 2][v_width-1:0]) * int'(stim_mem[base + 10]);
      if (int'(stim_mem[base + 11]) < min_pct) begin
        min_pct = int'(stim_mem[base + 11]);
      end
    end
    assert (min_pct > 0) else stop_on_error("a ready percentage of zero never finishes");
    cycle_limit = total_words * 100 / min_pct + row_count * (reset_cycles + 16) + 1000;
  endtask

  // --------------------------------------------------------------------------
  // One configuration row
  // --------------------------------------------------------------------------
  task automatic run_row(input int row);
    raster_cfg_t  row_cfg;
    vid_std_u     row_std;
    model_state_t st;
    vid_word_t    exp_word;
    vid_word_t    held_word;
    logic         holding;
    int           base;
    int           frames;
    int           pct;
    int           exp_trs;
    int           exp_active;
    int           idle_edges;
    int           words_seen;
    int           frames_done;
    int           trs_count;
    int           active_count;
    base = row * row_fields;
    row_cfg.h_limit = stim_mem[base][h_width-1:0];
    row_cfg.h_sav = stim_mem[base + 1][h_width-1:0];
    row_cfg.v_limit = stim_mem[base + 2][v_width-1:0];
    row_cfg.v1_start = stim_mem[base + 3][v_width-1:0];
    row_cfg.v1_end = stim_mem[base + 4][v_width-1:0];
    row_cfg.v2_start = stim_mem[base + 5][v_width-1:0];
    row_cfg.v2_end = stim_mem[base + 6][v_width-1:0];
    row_cfg.f1_start = stim_mem[base + 7][v_width-1:0];
    row_cfg.f2_start = stim_mem[base + 8][v_width-1:0];
    row_std.raw = stim_mem[base + 9];
    frames = int'(stim_mem[base + 10]);
    pct = int'(stim_mem[base + 11]);
    exp_trs = int'(stim_mem[base + 12]);
    exp_active = int'(stim_mem[base + 13]);

    @(posedge vid_clk);
    vid_reset <= 1'b1;
    cfg <= row_cfg;
    std_word <= row_std;
    out_ready <= 1'b0;
    repeat (reset_cycles) @(posedge vid_clk);
    assert (out_valid == 1'b0) else stop_on_error("out_valid high during reset");
    vid_reset <= 1'b0;
    out_ready <= pick_ready(pct);

    // Three stages fill before the first word shows
    idle_edges = 0;
    @(posedge vid_clk);
    while (!out_valid) begin
      idle_edges++;
      assert (idle_edges <= 3) else stop_on_error("out_valid did not rise after reset");
      out_ready <= pick_ready(pct);
      @(posedge vid_clk);
    end
    assert (idle_edges == 3) else stop_on_error("first word not on third edge after reset");

    st = first_position(row_cfg, row_std);
    holding = 1'b0;
    words_seen = 0;
    frames_done = 0;
    trs_count = 0;
    active_count = 0;
    while (frames_done < frames) begin
      if (holding) begin
        assert (out_valid) else stop_on_error("out_valid fell without a transfer");
        assert (out_word == held_word)
          else show_mismatch("out_word while stalled", 32'(out_word), 32'(held_word));
      end
      if (pct == 100) begin
        assert (out_valid) else stop_on_error("gap in output with out_ready held high");
      end
      if (out_valid && out_ready) begin
        cur_line = int'(st.v_pos);
        cur_sample = int'(st.h_pos);
        if (words_seen == 0) begin
          assert (out_word.trs && out_word.data == {trs_preamble, trs_preamble})
            else stop_on_error("first word after reset is not an EAV preamble with trs");
        end else if (words_seen < 3) begin
          assert (out_word.data == 20'h0 && !out_word.trs)
            else stop_on_error("EAV word after the preamble is not zero");
        end else if (words_seen == 3) begin
          assert (out_word.data[19] && out_word.data[9])
            else stop_on_error("fourth word is not an EAV XYZ word");
        end
        exp_word = expected_word(row_cfg, row_std, st);
        assert (out_word.data == exp_word.data)
          else show_mismatch("out_word.data", 32'(out_word.data), 32'(exp_word.data));
        assert (out_word.trs == exp_word.trs)
          else show_mismatch("out_word.trs", 32'(out_word.trs), 32'(exp_word.trs));
        assert (out_word.fvh == exp_word.fvh)
          else show_mismatch("out_word.fvh", 32'(out_word.fvh), 32'(exp_word.fvh));
        words_seen++;
        if (out_word.trs) begin
          trs_count++;
        end
        if (st.h_pos == h_width'(1) && !out_word.fvh[1]) begin
          active_count++;
        end
        // Per-frame totals at the last sample of the last line
        if (st.h_pos == row_cfg.h_limit && st.v_pos == row_cfg.v_limit) begin
          assert (trs_count == exp_trs)
            else show_mismatch("trs count per frame", 32'(trs_count), 32'(exp_trs));
          assert (trs_count == 2 * int'(row_cfg.v_limit))
            else show_mismatch("trs count per frame", 32'(trs_count),
                               32'(2 * int'(row_cfg.v_limit)));
          assert (active_count == exp_active)
            else show_mismatch("active lines per frame", 32'(active_count), 32'(exp_active));
          frames_done++;
          trs_count = 0;
          active_count = 0;
        end
        st = next_position(row_cfg, row_std, st);
        holding = 1'b0;
      end else if (out_valid) begin
        holding = 1'b1;
        held_word = out_word;
      end
      if (frames_done < frames) begin
        out_ready <= pick_ready(pct);
        @(posedge vid_clk);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    vid_reset = 1'b1;
    out_ready = 1'b0;
    cfg = '0;
    std_word = '0;
    void'($urandom(68));
    load_stimulus();
    for (int r = 0; r < row_count; r++) begin
      run_row(r);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/timing_input.txt ====
// h_limit h_sav v_limit v1_start v1_end v2_start v2_end f1_start f2_start std_word
// frames ready_pct trs_per_frame active_lines_per_frame, all hex
// Interlaced YUV, two fields of six active lines
28 14 14 3 9 d 13 1 b 85C60100 2 32 28 c
// Progressive 4:4:4 RGB
30 18 10 3 e 3 e 1 0 89490200 2 46 20 b
// Progressive RGBA with out_ready always high
20 c c 2 b 2 b 1 0 85090600 2 64 18 9
// Interlaced RGBD with sparse out_ready
24 10 a 2 5 7 a 1 6 85860a00 3 1e 14 6

// ==== sources.f ====
+incdir+include
hw/vid_timing_pkg.sv
hw/raster_counter.sv
hw/line_flags.sv
hw/trs_formatter.sv
hw/vid_timing_gen.sv
sim/vid_timing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module vid_timing_tb \
  -f sources.f --Mdir obj_dir -o vid_timing_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/vid_timing_sim > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
